/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module fifo_tb -f sources.f --Mdir obj_dir -o fifo_tb
	@out="$$(./obj_dir/fifo_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* fifo_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_assertions import fifo_pkg::*; (
    input wire                  clk,
    input wire                  rstReadAddr,
    input wire                  flush,
    input wire                  pop,
    input wire                  pop_valid,
    input wire                  full,
    input wire                  overflow,
    input wire [DATA_WIDTH-1:0] pop_data
);

    // Output drops while the pointers clear
    a_no_valid_after_flush: assert property (
        @(posedge clk) disable iff (rstReadAddr) flush |=> !pop_valid
    ) else $error("pop_valid high in the cycle after a flush");

    a_overflow_needs_full: assert property (
        @(posedge clk) disable iff (rstReadAddr) overflow |-> $past(full)
    ) else $error("overflow without full in the previous cycle");

    // Head word held under back-pressure
    a_head_stable: assert property (
        @(posedge clk) disable iff (rstReadAddr) (pop_valid && !pop) |=> $stable(pop_data)
    ) else $error("pop_data changed while waiting for a pop");

    a_clean_after_reset: assert property (
        @(posedge clk) $fell(rstReadAddr) |-> (!full && !pop_valid)
    ) else $error("full or pop_valid high right after reset");

endmodule

bind fifo_top fifo_assertions i_assertions (
    .clk         (clk),
    .rstReadAddr (rstReadAddr),
    .flush       (flush),
    .pop         (pop),
    .pop_valid   (pop_valid),
    .full        (full),
    .overflow    (overflow),
    .pop_data    (pop_data)
);

`default_nettype wire

/* fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // Payload and storage geometry
    localparam int DATA_WIDTH = 20;
    localparam int DEPTH_LOG2 = 5;
    localparam int FIFO_DEPTH = 1 << DEPTH_LOG2;

    // One extra bit so a full FIFO can be counted
    localparam int COUNT_WIDTH = DEPTH_LOG2 + 1;

    // Read side states
    typedef enum logic [1:0] {
        IDLE,
        SHOW,
        FLUSH
    } read_state_t;

endpackage

`default_nettype wire

/* fifo_pointers.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_pointers import fifo_pkg::*; (
    input  wire                    clk,
    input  wire                    rstReadAddr,
    input  wire                    push,
    input  wire                    advance_read,
    input  wire                    flush_clear,
    output logic [DEPTH_LOG2-1:0]  wr_ptr,
    output logic [DEPTH_LOG2-1:0]  rd_ptr,
    output logic [COUNT_WIDTH-1:0] words_committed,
    output logic                   full,
    output logic                   overflow,
    output logic                   accept,
    output logic                   word_commit
);

    logic [COUNT_WIDTH-1:0] words_stored;

    assign full   = (words_stored == COUNT_WIDTH'(FIFO_DEPTH));
    assign accept = push && !full && !flush_clear;

    // Circular pointers
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (advance_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Accepted words, used for full
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            words_stored <= '0;
        end else if (flush_clear) begin
            words_stored <= '0;
        end else begin
            case ({accept, advance_read})
                2'b10: words_stored <= words_stored + 1'b1;
                2'b01: words_stored <= words_stored - 1'b1;
                default: ;
            endcase
        end
    end

    // Words the memory has actually stored, one edge behind
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            word_commit     <= 1'b0;
            words_committed <= '0;
        end else if (flush_clear) begin
            word_commit     <= 1'b0;
            words_committed <= '0;
        end else begin
            word_commit <= accept;
            case ({word_commit, advance_read})
                2'b10: words_committed <= words_committed + 1'b1;
                2'b01: words_committed <= words_committed - 1'b1;
                default: ;
            endcase
        end
    end

    // Dropped push while full
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            overflow <= 1'b0;
        end else begin
            overflow <= push && full && !flush_clear;
        end
    end

endmodule

`default_nettype wire

/* fifo_read_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_read_fsm import fifo_pkg::*; (
    input  wire                    clk,
    input  wire                    rstReadAddr,
    input  wire                    pop,
    input  wire                    flush,
    input  wire                    word_commit,
    input  wire  [COUNT_WIDTH-1:0] words_committed,
    input  wire  [DEPTH_LOG2-1:0]  rd_ptr,
    output logic                   pop_valid,
    output logic                   advance_read,
    output logic                   flush_clear,
    output logic [DEPTH_LOG2-1:0]  next_read_addr,
    output logic                   read_address_stall
);

    read_state_t state;
    read_state_t state_next;
    logic        last_word;

    assign pop_valid    = (state == SHOW);
    assign advance_read = pop_valid && pop;
    assign flush_clear  = (state == FLUSH);

    // Head is the only committed word and nothing lands behind it
    assign last_word = (words_committed == COUNT_WIDTH'(1)) && !word_commit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (words_committed != '0) begin
                    state_next = SHOW;
                end
            end
            SHOW: begin
                if (advance_read && last_word) begin
                    state_next = IDLE;
                end
            end
            FLUSH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
        if (flush) begin
            state_next = FLUSH;
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Prefetch the following word on a pop, freeze the head otherwise
    always_comb begin
        next_read_addr     = rd_ptr;
        read_address_stall = 1'b0;
        case (state)
            SHOW: begin
                if (advance_read) begin
                    next_read_addr = rd_ptr + 1'b1;
                end else begin
                    read_address_stall = 1'b1;
                end
            end
            FLUSH: begin
                // Pointers restart at zero
                next_read_addr = '0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* fifo_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_tb import fifo_pkg::*; ;

    // Generous bound on the length of all tests
    localparam int unsigned CYCLE_LIMIT = 2000;

    logic                  clk = 1'b0;
    logic                  rstReadAddr;
    logic                  push;
    logic [DATA_WIDTH-1:0] push_data;
    logic                  pop;
    logic                  flush;
    logic [DATA_WIDTH-1:0] pop_data;
    logic                  pop_valid;
    logic                  full;
    logic                  overflow;

    logic [DATA_WIDTH-1:0] exp_q[$];
    int unsigned           errors = 0;
    int unsigned           checks = 0;
    int unsigned           cycles = 0;

    fifo_top i_dut (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .flush       (flush),
        .pop_data    (pop_data),
        .pop_valid   (pop_valid),
        .full        (full),
        .overflow    (overflow)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_word(input string test, input string what,
                              input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error [%s] %s: expected %h, actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string test, input string what,
                             input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error [%s] %s: expected %b, actual %b", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic clock_cycle();
        @(posedge clk);
        #1;
    endtask

    // One clock of traffic; the head is checked before it is popped
    task automatic drive_cycle(input string test, input bit do_push,
                               input logic [DATA_WIDTH-1:0] data, input bit want_pop,
                               output bit popped);
        bit model_full;
        model_full = (exp_q.size() >= FIFO_DEPTH);
        popped = 1'b0;
        if (want_pop && pop_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("In %s pop_valid is high but no word is expected", test);
                errors++;
            end
            if (exp_q.size() != 0) begin
                check_word(test, "pop_data", exp_q.pop_front(), pop_data);
            end
            pop    = 1'b1;
            popped = 1'b1;
        end
        if (do_push) begin
            push      = 1'b1;
            push_data = data;
            // A push into a full FIFO is dropped even when a pop frees a slot
            if (!model_full) begin
                exp_q.push_back(data);
            end
        end
        clock_cycle();
        push = 1'b0;
        pop  = 1'b0;
    endtask

    task automatic push_words(input string test, input int n);
        bit popped;
        repeat (n) begin
            drive_cycle(test, 1'b1, DATA_WIDTH'($urandom), 1'b0, popped);
        end
    endtask

    task automatic drain_words(input string test, input int n);
        int count;
        bit popped;
        count = 0;
        while (count < n) begin
            drive_cycle(test, 1'b0, '0, 1'b1, popped);
            if (popped) begin
                count++;
            end
        end
    endtask

    task automatic check_empty(input string test);
        check_bit(test, "pop_valid when drained", 1'b0, pop_valid);
    endtask

    task automatic reset_and_first_word();
        logic [DATA_WIDTH-1:0] word;
        bit                    popped;
        word = DATA_WIDTH'($urandom);
        check_bit("reset", "pop_valid", 1'b0, pop_valid);
        check_bit("reset", "full", 1'b0, full);
        check_bit("reset", "overflow", 1'b0, overflow);
        drive_cycle("first_word", 1'b1, word, 1'b0, popped);
        check_bit("first_word", "pop_valid at push edge", 1'b0, pop_valid);
        clock_cycle();
        check_bit("first_word", "pop_valid one edge later", 1'b0, pop_valid);
        clock_cycle();
        check_bit("first_word", "pop_valid two edges later", 1'b1, pop_valid);
        check_word("first_word", "pop_data", word, pop_data);
        drain_words("first_word", 1);
        check_empty("first_word");
    endtask

    task automatic ordered_streaming();
        bit popped;
        repeat (20) begin
            drive_cycle("streaming", 1'b1, DATA_WIDTH'($urandom), 1'b1, popped);
        end
        drain_words("streaming", exp_q.size());
        check_empty("streaming");
    endtask

    task automatic backpressure_full();
        logic [DATA_WIDTH-1:0] first;
        bit                    popped;
        push_words("backpressure", FIFO_DEPTH);
        first = exp_q[0];
        check_bit("backpressure", "full after last push", 1'b1, full);
        check_bit("backpressure", "pop_valid", 1'b1, pop_valid);
        check_word("backpressure", "head while full", first, pop_data);
        // Dropped by the DUT and kept out of the reference
        drive_cycle("backpressure", 1'b1, DATA_WIDTH'($urandom), 1'b0, popped);
        check_bit("backpressure", "overflow pulse", 1'b1, overflow);
        clock_cycle();
        check_bit("backpressure", "overflow after pulse", 1'b0, overflow);
        drain_words("backpressure", FIFO_DEPTH);
        check_empty("backpressure");
    endtask

    task automatic pointer_wraparound();
        int remaining;
        int n;
        remaining = 100;
        while (remaining > 0) begin
            n = (remaining < 24) ? remaining : 24;
            push_words("wraparound", n);
            drain_words("wraparound", n);
            remaining -= n;
        end
        check_empty("wraparound");
    endtask

    task automatic flush_midstream();
        push_words("flush", FIFO_DEPTH);
        clock_cycle();
        clock_cycle();
        check_bit("flush", "full before flush", 1'b1, full);
        flush = 1'b1;
        clock_cycle();
        flush = 1'b0;
        exp_q.delete();
        check_bit("flush", "pop_valid during flush", 1'b0, pop_valid);
        clock_cycle();
        check_bit("flush", "pop_valid after flush", 1'b0, pop_valid);
        check_bit("flush", "full after flush", 1'b0, full);
        push_words("flush", 1);
        drain_words("flush", 1);
        check_empty("flush");
    endtask

    task automatic pop_while_empty();
        pop = 1'b1;
        repeat (3) begin
            clock_cycle();
            check_bit("empty_pop", "pop_valid", 1'b0, pop_valid);
            check_bit("empty_pop", "full", 1'b0, full);
        end
        pop = 1'b0;
        push_words("empty_pop", 1);
        drain_words("empty_pop", 1);
        check_empty("empty_pop");
    endtask

    initial begin
        void'($urandom(69));
        rstReadAddr = 1'b1;
        push        = 1'b0;
        push_data   = '0;
        pop         = 1'b0;
        flush       = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstReadAddr = 1'b0;

        reset_and_first_word();
        ordered_streaming();
        backpressure_full();
        pointer_wraparound();
        flush_midstream();
        pop_while_empty();

        $display("Finished: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fifo_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fifo_top import fifo_pkg::*; (
    input  wire                   clk,
    input  wire                   rstReadAddr,
    input  wire                   push,
    input  wire  [DATA_WIDTH-1:0] push_data,
    input  wire                   pop,
    input  wire                   flush,
    output logic [DATA_WIDTH-1:0] pop_data,
    output logic                  pop_valid,
    output logic                  full,
    output logic                  overflow
);

    logic [DEPTH_LOG2-1:0]  wr_ptr;
    logic [DEPTH_LOG2-1:0]  rd_ptr;
    logic [DEPTH_LOG2-1:0]  next_read_addr;
    logic [COUNT_WIDTH-1:0] words_committed;
    logic                   accept;
    logic                   word_commit;
    logic                   advance_read;
    logic                   flush_clear;
    logic                   read_address_stall;

    fifo_pointers i_pointers (
        .clk             (clk),
        .rstReadAddr     (rstReadAddr),
        .push            (push),
        .advance_read    (advance_read),
        .flush_clear     (flush_clear),
        .wr_ptr          (wr_ptr),
        .rd_ptr          (rd_ptr),
        .words_committed (words_committed),
        .full            (full),
        .overflow        (overflow),
        .accept          (accept),
        .word_commit     (word_commit)
    );

    fifo_read_fsm i_read_fsm (
        .clk                (clk),
        .rstReadAddr        (rstReadAddr),
        .pop                (pop),
        .flush              (flush),
        .word_commit        (word_commit),
        .words_committed    (words_committed),
        .rd_ptr             (rd_ptr),
        .pop_valid          (pop_valid),
        .advance_read       (advance_read),
        .flush_clear        (flush_clear),
        .next_read_addr     (next_read_addr),
        .read_address_stall (read_address_stall)
    );

    // Unregistered output keeps one word per cycle on the read port
    mlab_memory #(
        .OUTPUT_REGISTER (1'b0)
    ) i_memory (
        .clk                (clk),
        .rstReadAddr        (rstReadAddr),
        .write_enable       (accept),
        .write_addr         (wr_ptr),
        .data_in            (push_data),
        .read_address_stall (read_address_stall),
        .read_addr          (next_read_addr),
        .data_out           (pop_data)
    );

endmodule

`default_nettype wire

/* mlab_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module mlab_memory import fifo_pkg::*; #(
    parameter bit OUTPUT_REGISTER = 1'b0
) (
    input  wire                   clk,
    input  wire                   rstReadAddr,

    // Write port
    input  wire                   write_enable,
    input  wire  [DEPTH_LOG2-1:0] write_addr,
    input  wire  [DATA_WIDTH-1:0] data_in,

    // Read port
    input  wire                   read_address_stall,
    input  wire  [DEPTH_LOG2-1:0] read_addr,
    output logic [DATA_WIDTH-1:0] data_out
);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    logic                  write_enable_q;
    logic [DEPTH_LOG2-1:0] write_addr_q;
    logic [DATA_WIDTH-1:0] write_data_q;

    logic [DEPTH_LOG2-1:0] read_addr_q;
    logic [DATA_WIDTH-1:0] read_word;

    // Write request is captured first
    always_ff @(posedge clk) begin
        write_enable_q <= write_enable;
        write_addr_q   <= write_addr;
        write_data_q   <= data_in;
    end

    // Array update one edge after capture
    always_ff @(posedge clk) begin
        if (write_enable_q) begin
            mem[write_addr_q] <= write_data_q;
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            read_addr_q <= '0;
        end else if (!read_address_stall) begin
            read_addr_q <= read_addr;
        end
    end

    // Mixed-port collision with the pending write is undefined
    assign read_word = (write_enable_q && (write_addr_q == read_addr_q)) ?
                       {DATA_WIDTH{1'bx}} : mem[read_addr_q];

    generate
        if (OUTPUT_REGISTER) begin : g_out_reg
            logic [DATA_WIDTH-1:0] read_word_q;

            always_ff @(posedge clk) begin
                read_word_q <= read_word;
            end

            assign data_out = read_word_q;
        end else begin : g_out_comb
            assign data_out = read_word;
        end
    endgenerate

endmodule

`default_nettype wire

/* sources.f */
fifo_pkg.sv
mlab_memory.sv
fifo_pointers.sv
fifo_read_fsm.sv
fifo_top.sv
fifo_assertions.sv
fifo_tb.sv
